// File: source/vic_pkg.sv
package vic_pkg;

  // ========================================
  // CPU register map
  // ========================================

  // Only the low six address bits reach the chip
  localparam logic [5:0] reg_ctrl1      = 6'h11;
  localparam logic [5:0] reg_raster     = 6'h12;
  localparam logic [5:0] reg_mem_ptr    = 6'h18;
  localparam logic [5:0] reg_irq_status = 6'h19;
  localparam logic [5:0] reg_irq_enable = 6'h1A;
  localparam logic [5:0] reg_border     = 6'h20;
  localparam logic [5:0] reg_background = 6'h21;

  // ========================================
  // Bus cycle phases
  // ========================================

  // Data of the first-half video fetch is valid at the end of this phase
  localparam logic [2:0] phase_fetch_latch = 3'd3;
  // Last phase of phi02 high, where the CPU access completes
  localparam logic [2:0] phase_cpu_latch   = 3'd7;
  // Data of the second-half character fetch is valid here
  localparam logic [2:0] phase_char_latch  = 3'd7;

  // ========================================
  // Control register 1
  // ========================================

  // The CPU moves the whole byte, the timing logic looks at fields
  // Only rst8 and den have an effect, the rest is kept for readback
  typedef union packed {
    logic [7:0] raw;
    struct packed {
      logic       rst8;
      logic       ecm;
      logic       bmm;
      logic       den;
      logic       rsel;
      logic [2:0] yscroll;
    } f;
  } ctrl1_u;

endpackage

// File: source/bus_sequencer.sv
`timescale 1ns/10ps

module bus_sequencer
  import vic_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       in_window,
  output logic       phi02,
  output logic       aec,
  output logic       ba,
  output logic       ras_n,
  output logic       cas_n,
  output logic       fetch_half,
  output logic       fetch_strobe,
  output logic       cpu_strobe,
  output logic [2:0] phase
);

  // Window flag as it stood during the previous bus cycle
  logic in_prev;
  // The current bus cycle carries a character fetch in its second half
  logic disp_cycle;

  // ========================================
  // Phase counter
  // ========================================

  always_ff @(posedge clk) begin
    if (rst) begin
      phase   <= 3'd0;
      in_prev <= 1'b0;
    end else begin
      // Eight clocks make one bus cycle and the counter simply wraps
      phase <= phase + 3'd1;
      // Sample the window once per cycle, at its last phase
      if (phase == phase_cpu_latch) begin
        in_prev <= in_window;
      end
    end
  end

  // The window opens one cycle early to give the CPU warning through ba,
  // so the first flagged cycle of a line is not yet a display cycle
  assign disp_cycle = in_window & in_prev;

  // phi02 follows the top phase bit, high in phases 4 to 7
  assign phi02 = phase[2];

  // Video owns the first half always, and the second half in display cycles
  assign aec = phase[2] & ~disp_cycle;

  // Bus request covers the warning cycle and all display cycles
  assign ba = ~in_window;

  // Matrix fetch in the first half, character fetch in the second
  assign fetch_half = phase[2];

  // ras_n falls one phase into a video half, cas_n one phase after that
  assign ras_n = ~((phase[1:0] != 2'd0) & (~phase[2] | disp_cycle));
  assign cas_n = ~(phase[1] & (~phase[2] | disp_cycle));

  // Data strobes close each video fetch
  assign fetch_strobe = (phase == phase_fetch_latch) |
                        ((phase == phase_char_latch) & disp_cycle);

  // The CPU port is sampled as phi02 is about to fall
  assign cpu_strobe = (phase == phase_cpu_latch);

  // ========================================
  // Checks
  // ========================================

  // A column strobe never appears without an open row
  a_cas_inside_ras : assert property (
    @(posedge clk) disable iff (rst) !cas_n |-> !ras_n
  ) else $error("cas_n low without ras_n low");

  // The memory bus is never strobed while the CPU owns it
  a_ras_video_owned : assert property (
    @(posedge clk) disable iff (rst) !ras_n |-> !aec
  ) else $error("ras_n low while aec is high");

endmodule

// File: source/register_file.sv
`timescale 1ns/10ps

module register_file
  import vic_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       cpu_strobe,
  input  logic       cs_n,
  input  logic       rw,
  input  logic [5:0] cpu_adr,
  input  logic [7:0] cpu_din,
  input  logic [8:0] line,
  input  logic       line_start,
  output logic [7:0] cpu_dout,
  output ctrl1_u     ctrl1,
  output logic [7:0] mem_ptr,
  output logic [3:0] border,
  output logic [3:0] background,
  output logic       irq
);

  // Low byte of the raster compare value
  // Bit 8 of the compare lives in ctrl1
  logic [7:0] raster_cmp;
  // Raster interrupt status and enable
  // Only source 0 exists
  logic       irq_stat;
  logic       irq_en;
  logic       cpu_wr;
  logic       raster_hit;
  logic [7:0] rd_data;

  // A write completes at the end of phi02 high with the chip selected
  assign cpu_wr = cpu_strobe & ~cs_n & ~rw;

  // Full nine-bit compare against the beam line
  assign raster_hit = line_start & (line == {ctrl1.f.rst8, raster_cmp});

  // ========================================
  // Register writes and interrupt status
  // ========================================

  always_ff @(posedge clk) begin
    if (rst) begin
      // Display enabled with 25 rows and default scroll out of reset
      ctrl1.raw  <= 8'h1B;
      raster_cmp <= 8'h00;
      mem_ptr    <= 8'h00;
      irq_en     <= 1'b0;
      border     <= 4'h0;
      background <= 4'h0;
      irq_stat   <= 1'b0;
    end else begin
      if (cpu_wr) begin
        case (cpu_adr)
          reg_ctrl1:      ctrl1.raw  <= cpu_din;
          reg_raster:     raster_cmp <= cpu_din;
          reg_mem_ptr:    mem_ptr    <= cpu_din;
          reg_irq_enable: irq_en     <= cpu_din[0];
          reg_border:     border     <= cpu_din[3:0];
          reg_background: background <= cpu_din[3:0];
          default: ;
        endcase
      end
      // Status is sticky
      // The compare sets it and writing a 1 clears it
      // The compare fires at phase 0 and writes land at phase 7
      if (raster_hit) begin
        irq_stat <= 1'b1;
      end else if (cpu_wr && (cpu_adr == reg_irq_status) && cpu_din[0]) begin
        irq_stat <= 1'b0;
      end
    end
  end

  assign irq = irq_stat & irq_en;

  // ========================================
  // Read multiplexer
  // ========================================

  // Unused bits read back as ones
  always_comb begin
    case (cpu_adr)
      reg_ctrl1:      rd_data = ctrl1.raw;
      reg_raster:     rd_data = line[7:0];
      reg_mem_ptr:    rd_data = {mem_ptr[7:1], 1'b1};
      reg_irq_status: rd_data = {irq, 6'h3F, irq_stat};
      reg_irq_enable: rd_data = {7'h7F, irq_en};
      reg_border:     rd_data = {4'hF, border};
      reg_background: rd_data = {4'hF, background};
      default:        rd_data = 8'hFF;
    endcase
  end

  // The data bus idles high when the CPU is not reading the chip
  assign cpu_dout = (~cs_n & rw) ? rd_data : 8'hFF;

  // The interrupt line only rises on a raster match or when the CPU sets the enable
  a_irq_source : assert property (
    @(posedge clk) disable iff (rst)
    $rose(irq) |->
      $past(raster_hit || (cpu_wr && (cpu_adr == reg_irq_enable) && cpu_din[0]))
  ) else $error("irq rose without a raster match or an enable write");

endmodule

// File: source/raster_timer.sv
`timescale 1ns/10ps

module raster_timer
  import vic_pkg::*;
#(
  parameter int line_cycles = 63,
  parameter int frame_lines = 262,
  parameter int first_line  = 51,
  parameter int first_cycle = 16,
  parameter int text_cols   = 40,
  parameter int text_rows   = 25
) (
  input  logic       clk,
  input  logic       rst,
  input  logic [2:0] phase,
  input  ctrl1_u     ctrl1,
  output logic [8:0] line,
  output logic [6:0] cycle,
  output logic       line_start,
  output logic       in_window,
  output logic       hsync,
  output logic       vsync,
  output logic [4:0] text_row,
  output logic [2:0] row_line
);

  localparam logic [6:0] last_cycle = 7'(line_cycles - 1);
  localparam logic [8:0] last_line  = 9'(frame_lines - 1);
  // Eight raster lines per text row
  localparam logic [8:0] win_top    = 9'(first_line);
  localparam logic [8:0] win_bottom = 9'(first_line + text_rows * 8);
  // The window starts one cycle ahead of the first display cycle
  localparam logic [6:0] win_left   = 7'(first_cycle - 1);
  localparam logic [6:0] win_right  = 7'(first_cycle + text_cols);

  logic [8:0] rel_line;
  logic       row_ok;
  logic       col_ok;

  // ========================================
  // Beam counters
  // ========================================

  always_ff @(posedge clk) begin
    if (rst) begin
      cycle <= 7'd0;
      line  <= 9'd0;
    end else if (phase == phase_cpu_latch) begin
      // Advance at the end of every bus cycle
      if (cycle == last_cycle) begin
        cycle <= 7'd0;
        line  <= (line == last_line) ? 9'd0 : line + 9'd1;
      end else begin
        cycle <= cycle + 7'd1;
      end
    end
  end

  // Single clock marker at the very start of each line
  assign line_start = (phase == 3'd0) & (cycle == 7'd0);

  assign hsync = (cycle == 7'd0);
  assign vsync = (line == 9'd0);

  // Window is empty unless the display is enabled
  assign row_ok    = ctrl1.f.den & (line >= win_top) & (line < win_bottom);
  assign col_ok    = (cycle >= win_left) & (cycle < win_right);
  assign in_window = row_ok & col_ok;

  // Position inside the text area, only meaningful inside the window
  assign rel_line = line - win_top;
  assign text_row = rel_line[7:3];
  assign row_line = rel_line[2:0];

endmodule

// File: source/dram_addr_mux.sv
`timescale 1ns/10ps

module dram_addr_mux #(
  parameter int first_cycle = 16,
  parameter int text_cols   = 40
) (
  input  logic       clk,
  input  logic       rst,
  input  logic [2:0] phase,
  input  logic       fetch_half,
  input  logic       in_window,
  input  logic [6:0] cycle,
  input  logic [4:0] text_row,
  input  logic [2:0] row_line,
  input  logic [7:0] mem_ptr,
  input  logic [7:0] char_code,
  output logic [7:0] mem_adr
);

  localparam logic [6:0]  col_first = 7'(first_cycle);
  localparam logic [13:0] cols_w    = 14'(text_cols);

  // Offset of the current text row inside the video matrix
  logic [13:0] row_base;
  // Column of the cell being fetched
  logic [6:0]  col_idx;
  logic [13:0] vm_adr;
  logic [13:0] cg_adr;
  logic [13:0] fetch_adr;

  // ========================================
  // Row offset
  // ========================================

  // The row changes only at line boundaries, long before the first
  // matrix fetch of the line, so one clock of latency costs nothing
  always_ff @(posedge clk) begin
    if (rst) begin
      row_base <= 14'd0;
    end else begin
      row_base <= {9'd0, text_row} * cols_w;
    end
  end

  // ========================================
  // Fetch addresses
  // ========================================

  // Outside the window the matrix fetch is an idle access to column 0
  assign col_idx = in_window ? (cycle - col_first) : 7'd0;

  // Matrix base is in 1K steps
  assign vm_adr = {mem_ptr[7:4], 10'd0} + row_base + {7'd0, col_idx};

  // Character base is in 2K steps, eight bytes per glyph
  assign cg_adr = {mem_ptr[3:1], 11'd0} + {3'd0, char_code, 3'd0} + {11'd0, row_line};

  assign fetch_adr = fetch_half ? cg_adr : vm_adr;

  // ========================================
  // Row and column multiplexing
  // ========================================

  // First two phases of each half put out the row byte for ras_n, the
  // last two put out the upper six bits for cas_n
  assign mem_adr = phase[1] ? {2'b00, fetch_adr[13:8]} : fetch_adr[7:0];

endmodule

// File: source/pixel_serializer.sv
`timescale 1ns/10ps

module pixel_serializer (
  input  logic        clk,
  input  logic        rst,
  input  logic        fetch_strobe,
  input  logic        fetch_half,
  input  logic        in_window,
  input  logic [11:0] mem_din,
  input  logic [3:0]  border,
  input  logic [3:0]  background,
  output logic [7:0]  char_code,
  output logic [3:0]  pixel,
  output logic        disp_en
);

  // Colour nibble of the cell whose pattern is being fetched
  logic [3:0] color_q;
  // Cell currently on screen
  logic [7:0] shift_q;
  logic [3:0] shift_color;
  // Pixels left to show from the loaded cell
  logic [3:0] bit_cnt;
  logic       load;

  // Character fetch done in a display cycle, so a new cell is ready
  assign load = fetch_strobe & fetch_half & in_window;

  // ========================================
  // Matrix latch
  // ========================================

  // Code and colour arrive together at the end of the first half
  always_ff @(posedge clk) begin
    if (fetch_strobe && !fetch_half) begin
      char_code <= mem_din[7:0];
      color_q   <= mem_din[11:8];
    end
  end

  // ========================================
  // Shift register
  // ========================================

  // The pattern strobe falls on the bus cycle boundary, so the new cell
  // goes straight in while the next matrix fetch is still ahead
  always_ff @(posedge clk) begin
    if (load) begin
      shift_q     <= mem_din[7:0];
      shift_color <= color_q;
    end else begin
      shift_q <= {shift_q[6:0], 1'b0};
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      bit_cnt <= 4'd0;
    end else if (load) begin
      bit_cnt <= 4'd8;
    end else if (bit_cnt != 4'd0) begin
      bit_cnt <= bit_cnt - 4'd1;
    end
  end

  // ========================================
  // Colour select
  // ========================================

  assign disp_en = (bit_cnt != 4'd0);

  // Set bits take the cell colour, clear bits the background,
  // and everything outside the text area is border
  always_comb begin
    if (!disp_en) begin
      pixel = border;
    end else if (shift_q[7]) begin
      pixel = shift_color;
    end else begin
      pixel = background;
    end
  end

endmodule

// File: source/vic_lite_top.sv
`timescale 1ns/10ps

module vic_lite_top
  import vic_pkg::*;
#(
  parameter int line_cycles = 63,
  parameter int frame_lines = 262,
  parameter int first_line  = 51,
  parameter int first_cycle = 16,
  parameter int text_cols   = 40,
  parameter int text_rows   = 25
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        cs_n,
  input  logic        rw,
  input  logic [5:0]  cpu_adr,
  input  logic [7:0]  cpu_din,
  input  logic [11:0] mem_din,
  output logic [7:0]  cpu_dout,
  output logic        phi02,
  output logic        aec,
  output logic        ba,
  output logic        ras_n,
  output logic        cas_n,
  output logic [7:0]  mem_adr,
  output logic        irq,
  output logic        hsync,
  output logic        vsync,
  output logic [3:0]  pixel,
  output logic        disp_en
);

  // ========================================
  // Internal nets
  // ========================================

  logic [2:0] phase;
  logic       fetch_half;
  logic       fetch_strobe;
  logic       cpu_strobe;
  logic       in_window;
  logic       line_start;
  logic [8:0] line;
  logic [6:0] cycle;
  logic [4:0] text_row;
  logic [2:0] row_line;
  ctrl1_u     ctrl1;
  logic [7:0] mem_ptr;
  logic [3:0] border;
  logic [3:0] background;
  logic [7:0] char_code;

  bus_sequencer u_bus_sequencer (
    .clk          (clk),
    .rst          (rst),
    .in_window    (in_window),
    .phi02        (phi02),
    .aec          (aec),
    .ba           (ba),
    .ras_n        (ras_n),
    .cas_n        (cas_n),
    .fetch_half   (fetch_half),
    .fetch_strobe (fetch_strobe),
    .cpu_strobe   (cpu_strobe),
    .phase        (phase)
  );

  register_file u_register_file (
    .clk        (clk),
    .rst        (rst),
    .cpu_strobe (cpu_strobe),
    .cs_n       (cs_n),
    .rw         (rw),
    .cpu_adr    (cpu_adr),
    .cpu_din    (cpu_din),
    .line       (line),
    .line_start (line_start),
    .cpu_dout   (cpu_dout),
    .ctrl1      (ctrl1),
    .mem_ptr    (mem_ptr),
    .border     (border),
    .background (background),
    .irq        (irq)
  );

  // Frame geometry goes only to the blocks that count the beam
  raster_timer #(
    .line_cycles (line_cycles),
    .frame_lines (frame_lines),
    .first_line  (first_line),
    .first_cycle (first_cycle),
    .text_cols   (text_cols),
    .text_rows   (text_rows)
  ) u_raster_timer (
    .clk        (clk),
    .rst        (rst),
    .phase      (phase),
    .ctrl1      (ctrl1),
    .line       (line),
    .cycle      (cycle),
    .line_start (line_start),
    .in_window  (in_window),
    .hsync      (hsync),
    .vsync      (vsync),
    .text_row   (text_row),
    .row_line   (row_line)
  );

  dram_addr_mux #(
    .first_cycle (first_cycle),
    .text_cols   (text_cols)
  ) u_dram_addr_mux (
    .clk        (clk),
    .rst        (rst),
    .phase      (phase),
    .fetch_half (fetch_half),
    .in_window  (in_window),
    .cycle      (cycle),
    .text_row   (text_row),
    .row_line   (row_line),
    .mem_ptr    (mem_ptr),
    .char_code  (char_code),
    .mem_adr    (mem_adr)
  );

  pixel_serializer u_pixel_serializer (
    .clk          (clk),
    .rst          (rst),
    .fetch_strobe (fetch_strobe),
    .fetch_half   (fetch_half),
    .in_window    (in_window),
    .mem_din      (mem_din),
    .border       (border),
    .background   (background),
    .char_code    (char_code),
    .pixel        (pixel),
    .disp_en      (disp_en)
  );

endmodule

// File: testbench/vic_lite_tb.sv
`timescale 1ns/10ps

module vic_lite_tb
  import vic_pkg::*;
;

  // Small frame so a whole picture takes under two thousand clocks
  localparam int line_cycles = 12;
  localparam int frame_lines = 20;
  localparam int first_line  = 4;
  localparam int first_cycle = 2;
  localparam int text_cols   = 4;
  localparam int text_rows   = 1;
  localparam int frame_clks  = line_cycles * frame_lines * 8;
  localparam int cells       = text_cols * text_rows * 8;

  // Register values that the table leaves behind for the display tests
  localparam logic [7:0] mem_ptr_val = 8'h34;
  localparam logic [3:0] border_val  = 4'hE;
  localparam logic [3:0] bg_val      = 4'h6;

  logic        clk;
  logic        rst;
  logic        cs_n;
  logic        rw;
  logic [5:0]  cpu_adr;
  logic [7:0]  cpu_din;
  logic [11:0] mem_din;
  logic [7:0]  cpu_dout;
  logic        phi02;
  logic        aec;
  logic        ba;
  logic        ras_n;
  logic        cas_n;
  logic [7:0]  mem_adr;
  logic        irq;
  logic        hsync;
  logic        vsync;
  logic [3:0]  pixel;
  logic        disp_en;

  // Display memory and the 1K colour nibbles beside it
  logic [7:0]  mem [0:16383];
  logic [3:0]  color [0:1023];

  // Register table with one entry per access
  string       tbl_name[$];
  logic [5:0]  tbl_adr[$];
  bit          tbl_wr[$];
  logic [7:0]  tbl_data[$];
  logic [7:0]  tbl_exp[$];

  // Memory model and fetch monitor state
  logic [7:0]  row_q;
  logic [13:0] cur_adr;
  logic [13:0] last_ma;
  logic        cas_prev;
  logic [3:0]  exp_pix[$];
  bit          fetch_on;
  bit          off_on;
  int          fetch_cnt;
  int          pix_cnt;
  int          addr_err;
  int          pix_err;
  int          timing_err;
  int          off_disp;
  int          off_ba;
  int          pass_cnt;
  int          fail_cnt;
  int          clk_cnt;
  int          beam_clk;
  int          timeout_limit;

  vic_lite_top #(
    .line_cycles (line_cycles),
    .frame_lines (frame_lines),
    .first_line  (first_line),
    .first_cycle (first_cycle),
    .text_cols   (text_cols),
    .text_rows   (text_rows)
  ) u_vic_lite_top (
    .clk      (clk),
    .rst      (rst),
    .cs_n     (cs_n),
    .rw       (rw),
    .cpu_adr  (cpu_adr),
    .cpu_din  (cpu_din),
    .mem_din  (mem_din),
    .cpu_dout (cpu_dout),
    .phi02    (phi02),
    .aec      (aec),
    .ba       (ba),
    .ras_n    (ras_n),
    .cas_n    (cas_n),
    .mem_adr  (mem_adr),
    .irq      (irq),
    .hsync    (hsync),
    .vsync    (vsync),
    .pixel    (pixel),
    .disp_en  (disp_en)
  );

  always #4 clk = ~clk;

  // Run limit checked on every clock
  always @(posedge clk) begin
    clk_cnt <= clk_cnt + 1;
    if (clk_cnt >= timeout_limit) begin
      $display("timeout after %0d clocks, the tests did not complete", clk_cnt);
      $display("sim failed");
      $finish;
    end
  end

  // Clocks since the end of reset give the beam position
  always @(posedge clk) begin
    if (rst) begin
      beam_clk <= 0;
    end else begin
      beam_clk <= beam_clk + 1;
    end
  end

  // ========================================
  // Memory model
  // ========================================

  // Data for the captured address is ready one clock before the DUT latches it
  always @(posedge clk) begin
    mem_din <= {color[cur_adr[9:0]], mem[cur_adr]};
  end

  // Address capture, fetch checks and pixel checks are all sampled mid-clock
  always @(negedge clk) begin
    logic [3:0] want;
    if (!ras_n && cas_n) begin
      row_q = mem_adr;
    end
    if (!cas_n) begin
      cur_adr = {mem_adr[5:0], row_q};
      // On the first column phase of a fetch phi02 tells which half it is
      if (cas_prev) begin
        if (!phi02) begin
          last_ma = cur_adr;
        end else if (fetch_on) begin
          check_char_fetch(last_ma, cur_adr);
        end
      end
    end
    cas_prev = cas_n;
    if (fetch_on) begin
      check_bus_timing();
      if (disp_en) begin
        if (exp_pix.size() == 0) begin
          $display("disp_en was high with no fetched cell left to show");
          pix_err++;
        end else begin
          want = exp_pix.pop_front();
          pix_cnt++;
          if (pixel !== want) begin
            $display("ERROR pixel_stream expected %h actual %h", want, pixel);
            pix_err++;
          end
        end
      end else if (pixel !== border_val) begin
        $display("ERROR border_pixel expected %h actual %h", border_val, pixel);
        pix_err++;
      end
    end
    if (off_on && disp_en) begin
      off_disp++;
    end
    if (off_on && !ba) begin
      off_ba++;
    end
  end

  // ========================================
  // Helpers
  // ========================================

  // Fetch n of the frame is column n mod text_cols of window line n / text_cols
  task automatic check_char_fetch(input logic [13:0] ma, input logic [13:0] ca);
    int win_line;
    int exp_ma;
    int exp_ca;
    logic [7:0] pat;
    win_line = fetch_cnt / text_cols;
    exp_ma = int'(mem_ptr_val[7:4]) * 1024 + (win_line / 8) * text_cols +
             fetch_cnt % text_cols;
    exp_ca = int'(mem_ptr_val[3:1]) * 2048 + int'(mem[exp_ma]) * 8 + win_line % 8;
    if (ma !== 14'(exp_ma)) begin
      $display("ERROR matrix_addr expected %h actual %h", 14'(exp_ma), ma);
      addr_err++;
    end
    if (ca !== 14'(exp_ca)) begin
      $display("ERROR char_addr expected %h actual %h", 14'(exp_ca), ca);
      addr_err++;
    end
    // Pixels leave from pattern bit 7 down
    pat = mem[exp_ca];
    for (int b = 7; b >= 0; b--) begin
      exp_pix.push_back(pat[b] ? color[exp_ma % 1024] : bg_val);
    end
    fetch_cnt++;
  endtask

  // Bus ownership and sync pins follow from the phase, bus cycle and line
  task automatic check_bus_timing();
    int ph;
    int cyc;
    int ln;
    bit rows;
    bit disp;
    bit req;
    logic [4:0] exp_pins;
    logic [4:0] got_pins;
    ph   = beam_clk % 8;
    cyc  = (beam_clk / 8) % line_cycles;
    ln   = (beam_clk / (8 * line_cycles)) % frame_lines;
    rows = (ln >= first_line) && (ln < first_line + text_rows * 8);
    disp = rows && (cyc >= first_cycle) && (cyc < first_cycle + text_cols);
    // The bus request starts one cycle ahead of the first display cycle
    req  = rows && (cyc >= first_cycle - 1) && (cyc < first_cycle + text_cols);
    exp_pins = {ph >= 4, (ph >= 4) && !disp, !req, cyc == 0, ln == 0};
    got_pins = {phi02, aec, ba, hsync, vsync};
    if (got_pins !== exp_pins) begin
      $display("ERROR bus_timing expected %b actual %b", exp_pins, got_pins);
      timing_err++;
    end
  endtask

  task automatic add_entry(input string name, input logic [5:0] adr, input bit wr,
                           input logic [7:0] data, input logic [7:0] exp);
    tbl_name.push_back(name);
    tbl_adr.push_back(adr);
    tbl_wr.push_back(wr);
    tbl_data.push_back(data);
    tbl_exp.push_back(exp);
  endtask

  // phi02 rises on the clock edge that starts phase 4
  // The write lands at phase 7
  task automatic bus_write(input logic [5:0] adr, input logic [7:0] data);
    @(posedge phi02);
    cs_n    <= 1'b0;
    rw      <= 1'b0;
    cpu_adr <= adr;
    cpu_din <= data;
    @(posedge phi02);
    cs_n <= 1'b1;
    rw   <= 1'b1;
  endtask

  task automatic bus_read(input logic [5:0] adr, output logic [7:0] data);
    @(posedge phi02);
    cs_n    <= 1'b0;
    rw      <= 1'b1;
    cpu_adr <= adr;
    @(negedge clk);
    @(negedge clk);
    data = cpu_dout;
    @(posedge clk);
    cs_n <= 1'b1;
  endtask

  task automatic report_test(input string name, input int errs);
    if (errs == 0) begin
      $display("PASS %s", name);
      pass_cnt++;
    end else begin
      $display("FAIL %s with %0d errors", name, errs);
      fail_cnt++;
    end
  endtask

  // ========================================
  // Test sequence
  // ========================================

  initial begin
    int seed;
    int errs;
    int n;
    logic [7:0] rd;
    clk = 1'b0;
    rst = 1'b1;
    cs_n = 1'b1;
    rw = 1'b1;
    cpu_adr = 6'd0;
    cpu_din = 8'd0;
    mem_din = 12'd0;
    row_q = 8'd0;
    cur_adr = 14'd0;
    last_ma = 14'd0;
    cas_prev = 1'b1;
    clk_cnt = 0;
    seed = $urandom(32'ha450);
    for (int i = 0; i < 16384; i++) begin
      mem[i] = 8'($urandom);
    end
    for (int i = 0; i < 1024; i++) begin
      color[i] = 4'($urandom);
    end

    // Status bit 0 is already set because the compare value of 0 matched line 0
    add_entry("ctrl1_rw", reg_ctrl1, 1, 8'h1F, 8'h1F);
    add_entry("mem_ptr", reg_mem_ptr, 1, mem_ptr_val, mem_ptr_val | 8'h01);
    add_entry("border", reg_border, 1, {4'h5, border_val}, {4'hF, border_val});
    add_entry("background", reg_background, 1, {4'hA, bg_val}, {4'hF, bg_val});
    add_entry("irq_enable_off", reg_irq_enable, 1, 8'h00, 8'hFE);
    add_entry("irq_status_set", reg_irq_status, 0, 8'h00, 8'h7F);
    add_entry("irq_status_clear", reg_irq_status, 1, 8'h01, 8'h7E);
    add_entry("unused_write", 6'h3F, 1, 8'h12, 8'hFF);
    add_entry("unused_read", 6'h00, 0, 8'h00, 8'hFF);
    add_entry("ctrl1_restore", reg_ctrl1, 1, 8'h1B, 8'h1B);

    // Up to four frames of waiting in the display tests plus one frame spare
    timeout_limit = 16 + tbl_name.size() * 8 * 8 + 5 * frame_clks;

    // Reset state is checked in the last reset cycle
    errs = 0;
    repeat (15) @(posedge clk);
    @(negedge clk);
    if ({ras_n, cas_n, ba, irq, disp_en} !== 5'b11100) begin
      $display("ERROR reset_pins expected %b actual %b", 5'b11100,
               {ras_n, cas_n, ba, irq, disp_en});
      errs++;
    end
    @(posedge clk);
    rst <= 1'b0;
    bus_read(reg_ctrl1, rd);
    if (rd !== 8'h1B) begin
      $display("ERROR reset_ctrl1 expected %h actual %h", 8'h1B, rd);
      errs++;
    end
    report_test("reset_state", errs);

    for (int i = 0; i < tbl_name.size(); i++) begin
      errs = 0;
      if (tbl_wr[i]) begin
        bus_write(tbl_adr[i], tbl_data[i]);
      end
      bus_read(tbl_adr[i], rd);
      if (rd !== tbl_exp[i]) begin
        $display("ERROR %s expected %h actual %h", tbl_name[i], tbl_exp[i], rd);
        errs++;
      end
      report_test(tbl_name[i], errs);
    end

    // One whole frame of fetches and pixels
    @(posedge vsync);
    fetch_on = 1'b1;
    @(posedge vsync);
    fetch_on = 1'b0;
    if (fetch_cnt != cells) begin
      $display("only %0d of %0d character fetches were seen", fetch_cnt, cells);
      addr_err++;
    end
    if (pix_cnt != cells * 8 || exp_pix.size() != 0) begin
      $display("%0d pixels shown with %0d still owed", pix_cnt, exp_pix.size());
      pix_err++;
    end
    report_test("fetch_addr", addr_err);
    report_test("pixel_stream", pix_err);
    report_test("bus_timing", timing_err);

    // Raster interrupt on line 7
    errs = 0;
    bus_write(reg_raster, 8'd7);
    bus_write(reg_irq_status, 8'h01);
    bus_write(reg_irq_enable, 8'h01);
    n = 0;
    while (irq !== 1'b1 && n < frame_clks) begin
      @(negedge clk);
      n++;
    end
    if (irq !== 1'b1) begin
      $display("irq never rose within a frame of setting the compare");
      errs++;
    end else begin
      bus_read(reg_raster, rd);
      if (rd !== 8'd7) begin
        $display("ERROR irq_line expected %h actual %h", 8'd7, rd);
        errs++;
      end
      bus_write(reg_irq_status, 8'h01);
      @(negedge clk);
      if (irq !== 1'b0) begin
        $display("ERROR irq_clear expected %b actual %b", 1'b0, irq);
        errs++;
      end
    end
    report_test("raster_irq", errs);

    // Display off for one full frame
    errs = 0;
    bus_write(reg_ctrl1, 8'h0B);
    bus_read(reg_ctrl1, rd);
    if (rd !== 8'h0B) begin
      $display("ERROR den_off expected %h actual %h", 8'h0B, rd);
      errs++;
    end
    @(posedge vsync);
    off_on = 1'b1;
    @(posedge vsync);
    off_on = 1'b0;
    if (off_disp != 0) begin
      $display("disp_en rose on %0d clocks while the display was off", off_disp);
      errs++;
    end
    if (off_ba != 0) begin
      $display("ba fell on %0d clocks while the display was off", off_ba);
      errs++;
    end
    report_test("display_off", errs);

    $display("tests %0d passed %0d failed %0d", pass_cnt + fail_cnt, pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// File: list.f
source/vic_pkg.sv
source/bus_sequencer.sv
source/register_file.sv
source/raster_timer.sv
source/dram_addr_mux.sv
source/pixel_serializer.sv
source/vic_lite_top.sv
testbench/vic_lite_tb.sv
